// ==== source/sys_pkg.sv ====
package sys_pkg;

	// ==========================================================================
	// Download port and memory widths
	// ==========================================================================
	localparam int dl_addr_w     = 25;   // Host byte address
	localparam int dl_index_w    = 8;
	localparam int dl_data_w     = 8;
	localparam int rom_addr_w    = 22;   // ROM memory address
	localparam int rom_wr_addr_w = 24;   // ROM write counter

	localparam logic [dl_index_w-1:0] code_index = {dl_index_w{1'b1}}; // Cheat download
	localparam logic [4:0] handheld_index = 5'd2;  // Low index bits of a handheld image

	// Optional copier header in front of the cartridge image
	localparam int header_bytes = 512;

	// ==========================================================================
	// Clock enable divider
	// ==========================================================================
	localparam int ce_period = 30;
	localparam int ce_cnt_w  = $clog2(ce_period);

	// Counts after which the enable fires
	localparam logic [1:0][ce_cnt_w-1:0] ce_cpu_phases = {ce_cnt_w'(24), ce_cnt_w'(9)};
	localparam logic [2:0][ce_cnt_w-1:0] ce_pix_phases =
		{ce_cnt_w'(29), ce_cnt_w'(19), ce_cnt_w'(9)};
	localparam int ce_vdp_step = 5;  // VDP fires on the last count of every step

endpackage

// ==== source/cheat_pkg.sv ====
package cheat_pkg;

	localparam int code_bytes = 16;
	localparam int code_off_w = $clog2(code_bytes);

	// Field view with flags on top
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_fields_t;

	// Byte view indexed by download offset as bytes[off[3:2]][off[1:0]].
	// Outer index 0 is the flags word, inner index 0 its lowest byte
	typedef logic [0:code_bytes/4-1][3:0][7:0] cheat_bytes_t;

	// One 128-bit code word loaded by bytes and read by fields
	typedef union packed {
		cheat_fields_t field;
		cheat_bytes_t  bytes;
	} cheat_code_t;

	// Bytes 0-3 flags, 4-7 address, 8-11 compare, 12-15 replace
	// Each field takes its four bytes least significant first

endpackage

// ==== source/download_if.sv ====
interface download_if import sys_pkg::*; ();

	logic                  active;   // Download in progress
	logic [dl_index_w-1:0] index;    // Kind of download
	logic                  wr;       // One-cycle byte strobe
	logic [dl_addr_w-1:0]  addr;
	logic [dl_data_w-1:0]  data;
	logic                  wr_wait;  // Holds off the host

	// Host side drives the byte stream
	modport host (
		output active, index, wr, addr, data,
		input  wr_wait
	);

	// Loaders listen and the cartridge writer answers with wr_wait
	modport loader (
		input  active, index, wr, addr, data,
		output wr_wait
	);

endinterface

// ==== source/clock_enables.sv ====
module clock_enables import sys_pkg::*; (
	input  logic clk_sys,
	input  logic rst_n,
	output logic ce_cpu,
	output logic ce_vdp,
	output logic ce_pix,
	output logic ce_sp
);

	logic [ce_cnt_w-1:0] cnt;
	logic                cpu_hit;
	logic                pix_hit;
	logic                vdp_hit;

	// Phase decode of the current count
	always_comb begin
		cpu_hit = 1'b0;
		pix_hit = 1'b0;
		for (int i = 0; i < $size(ce_cpu_phases); i++) begin
			if (cnt == ce_cpu_phases[i]) cpu_hit = 1'b1;
		end
		for (int i = 0; i < $size(ce_pix_phases); i++) begin
			if (cnt == ce_pix_phases[i]) pix_hit = 1'b1;
		end
		vdp_hit = (int'(cnt) % ce_vdp_step) == ce_vdp_step - 1;  // 4, 9, 14 ...
	end

	// ==========================================================================
	// Divide-by-30 counter and registered enables
	// ==========================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cnt    <= '0;
			ce_cpu <= 1'b0;
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			ce_sp  <= 1'b0;
		end else begin
			if (cnt == ce_cnt_w'(ce_period - 1)) cnt <= '0;
			else cnt <= cnt + 1'b1;

			ce_cpu <= cpu_hit;   // Twice per period
			ce_vdp <= vdp_hit;   // Six times
			ce_pix <= pix_hit;   // Three times
			ce_sp  <= cnt[0];    // Every other cycle
		end
	end

endmodule

// ==== source/cart_writer.sv ====
module cart_writer import sys_pkg::*; (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	download_if.loader               dl,
	output logic                     rom_wr_req,
	input  logic                     rom_wr_ack,
	output logic [rom_wr_addr_w-1:0] rom_wr_addr
);

	logic cart_dl;     // Cartridge download in progress
	logic cart_dl_q;
	logic cart_start;
	logic cart_wr;
	logic wr_done;

	assign cart_dl    = dl.active && (dl.index != code_index);
	assign cart_start = cart_dl && !cart_dl_q;
	assign cart_wr    = dl.wr && cart_dl;

	// Memory has caught up with the last toggle
	assign wr_done = dl.wr_wait && (rom_wr_req == rom_wr_ack);

	// ==========================================================================
	// Toggle request and host hold-off
	// ==========================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cart_dl_q  <= 1'b0;
			rom_wr_req <= 1'b0;
			dl.wr_wait <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;

			if (cart_wr) begin
				rom_wr_req <= ~rom_wr_req;  // New write pending
				dl.wr_wait <= 1'b1;
			end else if (wr_done) begin
				dl.wr_wait <= 1'b0;         // Host may send the next byte
			end
		end
	end

	// Write address restarts with every new cartridge download
	always_ff @(posedge clk_sys) begin
		if (cart_start) begin
			rom_wr_addr <= '0;
		end else if (wr_done) begin
			rom_wr_addr <= rom_wr_addr + 1'b1;
		end
	end

	// Memory takes rom_wr_addr and dl.data with each toggle, so the
	// address only moves once the write has been answered

endmodule

// ==== source/cart_mapper.sv ====
module cart_mapper import sys_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	download_if.loader            dl,
	input  logic [rom_addr_w-1:0] rom_rd_addr,
	output logic [rom_addr_w-1:0] rom_mem_addr,
	output logic                  game_gear
);

	logic                  cart_dl;
	logic                  cart_dl_q;
	logic                  cart_wr;
	logic [rom_addr_w-1:0] wr_addr;
	logic [dl_addr_w-1:0]  next_addr;    // Length so far after this byte
	logic                  len_bit9;
	logic                  has_header;
	logic [rom_addr_w-1:0] mask_plain;
	logic [rom_addr_w-1:0] mask_hdr;

	assign cart_dl   = dl.active && (dl.index != code_index);
	assign cart_wr   = dl.wr && cart_dl;
	assign wr_addr   = dl.addr[rom_addr_w-1:0];
	assign next_addr = dl.addr + 1'b1;

	// ==========================================================================
	// Mask learning from the streamed addresses
	// ==========================================================================
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			if (dl.addr == '0) mask_plain <= '0;  // Restart on a new image
			else mask_plain <= mask_plain | wr_addr;

			if (dl.addr == dl_addr_w'(header_bytes)) mask_hdr <= '0;
			else mask_hdr <= mask_hdr | (wr_addr - rom_addr_w'(header_bytes));

			len_bit9 <= next_addr[9];
		end
	end

	// Handheld flag per byte, header flag at the end of the download
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cart_dl_q  <= 1'b0;
			game_gear  <= 1'b0;
			has_header <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			if (cart_wr) game_gear <= dl.index[4:0] == handheld_index;
			if (cart_dl_q && !cart_dl) has_header <= len_bit9;  // Odd 512 block
		end
	end

	// CPU address to memory address
	always_comb begin
		if (has_header) begin
			rom_mem_addr = (rom_rd_addr + rom_addr_w'(header_bytes)) & mask_hdr;
		end else begin
			rom_mem_addr = rom_rd_addr & mask_plain;
		end
	end

endmodule

// ==== source/cheat_loader.sv ====
module cheat_loader import sys_pkg::*, cheat_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	download_if.loader dl,
	output cheat_code_t code,
	output logic       code_valid
);

	logic                  code_dl;   // Cheat download in progress
	logic                  code_wr;
	logic [code_off_w-1:0] off;       // Byte offset within the code
	logic                  last_byte;

	assign code_dl   = dl.active && (dl.index == code_index);
	assign code_wr   = dl.wr && code_dl;
	assign off       = dl.addr[code_off_w-1:0];
	assign last_byte = off == code_off_w'(code_bytes - 1);

	// ==========================================================================
	// Byte assembly
	// ==========================================================================
	// Upper offset bits pick the field, lower ones the byte inside it
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			code.bytes[off[code_off_w-1:2]][off[1:0]] <= dl.data;
		end
	end

	// One pulse once the replace word is complete
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			code_valid <= 1'b0;
		end else begin
			code_valid <= code_wr && last_byte;
		end
	end

	// Fields keep their value until the next cheat download
	// overwrites them, so consumers may sample code at any time
	// after the pulse through code.field

endmodule

// ==== source/cart_top.sv ====
module cart_top import sys_pkg::*, cheat_pkg::*; (
	input  logic                     clk_sys,
	input  logic                     rst_n,

	// Host download port
	input  logic                     dl_active,
	input  logic [dl_index_w-1:0]    dl_index,
	input  logic                     dl_wr,
	input  logic [dl_addr_w-1:0]     dl_addr,
	input  logic [dl_data_w-1:0]     dl_data,
	output logic                     dl_wait,

	// ROM memory write side
	output logic                     rom_wr_req,
	input  logic                     rom_wr_ack,
	output logic [rom_wr_addr_w-1:0] rom_wr_addr,

	// ROM memory read side
	input  logic [rom_addr_w-1:0]    rom_rd_addr,
	output logic [rom_addr_w-1:0]    rom_mem_addr,
	output logic                     game_gear,

	output cheat_code_t              code,
	output logic                     code_valid,

	output logic                     ce_cpu,
	output logic                     ce_vdp,
	output logic                     ce_pix,
	output logic                     ce_sp
);

	download_if dl ();

	// Host side of the interface
	assign dl.active = dl_active;
	assign dl.index  = dl_index;
	assign dl.wr     = dl_wr;
	assign dl.addr   = dl_addr;
	assign dl.data   = dl_data;
	assign dl_wait   = dl.wr_wait;

	// ==========================================================================
	// Blocks
	// ==========================================================================
	clock_enables i_clock_enables (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.ce_cpu  (ce_cpu),
		.ce_vdp  (ce_vdp),
		.ce_pix  (ce_pix),
		.ce_sp   (ce_sp)
	);

	cart_writer i_cart_writer (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.dl          (dl.loader),
		.rom_wr_req  (rom_wr_req),
		.rom_wr_ack  (rom_wr_ack),
		.rom_wr_addr (rom_wr_addr)
	);

	cart_mapper i_cart_mapper (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.dl           (dl.loader),
		.rom_rd_addr  (rom_rd_addr),
		.rom_mem_addr (rom_mem_addr),
		.game_gear    (game_gear)
	);

	cheat_loader i_cheat_loader (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.dl         (dl.loader),
		.code       (code),
		.code_valid (code_valid)
	);

endmodule

// ==== test/tb_cart_checks.svh ====
`ifndef TB_CART_CHECKS_SVH
`define TB_CART_CHECKS_SVH

int n_checks = 0;
int n_errors = 0;

// ==========================================================================
// Compare tasks for each result type
// ==========================================================================
task automatic check_addr(input string name, input logic [rom_addr_w-1:0] exp,
		input logic [rom_addr_w-1:0] act);
	n_checks++;
	if (act !== exp) begin
		n_errors++;
		$display("** Error %s: expected %h, actual %h at %0t", name, exp, act, $time);
	end
endtask

task automatic check_wr_addr(input string name, input logic [rom_wr_addr_w-1:0] exp,
		input logic [rom_wr_addr_w-1:0] act);
	n_checks++;
	if (act !== exp) begin
		n_errors++;
		$display("** Error %s: expected %h, actual %h at %0t", name, exp, act, $time);
	end
endtask

task automatic check_data(input string name, input logic [dl_data_w-1:0] exp,
		input logic [dl_data_w-1:0] act);
	n_checks++;
	if (act !== exp) begin
		n_errors++;
		$display("** Error %s: expected %h, actual %h at %0t", name, exp, act, $time);
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	n_checks++;
	if (act !== exp) begin
		n_errors++;
		$display("** Error %s: expected %b, actual %b at %0t", name, exp, act, $time);
	end
endtask

// Fields shown flags first as the consumers read them
task automatic check_code(input string name, input cheat_code_t exp,
		input cheat_code_t act);
	n_checks++;
	if (act !== exp) begin
		n_errors++;
		$display("** Error %s: expected %h %h %h %h, actual %h %h %h %h", name,
			exp.field.flags, exp.field.address, exp.field.compare, exp.field.replace,
			act.field.flags, act.field.address, act.field.compare, act.field.replace);
	end
endtask

task automatic check_count(input string name, input int exp, input int act);
	n_checks++;
	if (act != exp) begin
		n_errors++;
		$display("** Error %s: expected %0d, actual %0d at %0t", name, exp, act, $time);
	end
endtask

`endif

// ==== test/tb_cart_top.sv ====
module tb_cart_top import sys_pkg::*, cheat_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int ready_timeout = 40;          // Cycles allowed for one ROM write
	localparam logic [31:0] lfsr_seed = 32'h7595;

	logic                     clk_sys = 1'b0;
	logic                     rst_n;
	logic                     dl_active;
	logic [dl_index_w-1:0]    dl_index;
	logic                     dl_wr;
	logic [dl_addr_w-1:0]     dl_addr;
	logic [dl_data_w-1:0]     dl_data;
	logic                     dl_wait;
	logic                     rom_wr_req;
	logic                     rom_wr_ack;
	logic [rom_wr_addr_w-1:0] rom_wr_addr;
	logic [rom_addr_w-1:0]    rom_rd_addr;
	logic [rom_addr_w-1:0]    rom_mem_addr;
	logic                     game_gear;
	cheat_code_t              code;
	logic                     code_valid;
	logic                     ce_cpu;
	logic                     ce_vdp;
	logic                     ce_pix;
	logic                     ce_sp;

	int rom_writes   = 0;   // Toggles answered by the memory model
	int cart_base    = 0;   // rom_writes at the start of the current download
	int valid_pulses = 0;

	`include "tb_cart_checks.svh"

	// ==========================================================================
	// Stimulus and expected value tables
	// ==========================================================================
	// Clock enables in bit order cpu, vdp, pix, sp
	localparam string ce_name [4] = '{"ce_cpu", "ce_vdp", "ce_pix", "ce_sp"};
	localparam int ce_first [4] = '{9, 4, 9, 1};     // Cycle of the first pulse
	localparam int ce_gap [4]   = '{15, 5, 10, 2};
	localparam int ce_total [4] = '{4, 12, 6, 30};   // Pulses in two periods

	localparam int n_cart = 2;
	logic [dl_index_w-1:0] cart_index [n_cart] = '{8'h22, 8'h01};
	int                    cart_len [n_cart]   = '{8704, 8192};  // 8 KB plus header, 8 KB
	logic                  cart_gg [n_cart]    = '{1'b1, 1'b0};
	logic [rom_addr_w-1:0] rd_tab [n_cart][4] = '{
		'{22'h000000, 22'h001E00, 22'h001234, 22'h3FFFFF},
		'{22'h000000, 22'h001234, 22'h0ABCDE, 22'h3FFFFF}};
	logic [rom_addr_w-1:0] mem_tab [n_cart][4] = '{
		'{22'h000200, 22'h000000, 22'h001434, 22'h0001FF},  // (rd + 512) & 8191
		'{22'h000000, 22'h001234, 22'h001CDE, 22'h001FFF}}; // rd & 8191

	localparam int n_cheat = 2;
	logic [7:0] cheat_tab [n_cheat][code_bytes] = '{
		'{8'h00, 8'h01, 8'h02, 8'h03, 8'h04, 8'h05, 8'h06, 8'h07,
		  8'h08, 8'h09, 8'h0A, 8'h0B, 8'h0C, 8'h0D, 8'h0E, 8'h0F},
		'{8'h01, 8'h00, 8'h00, 8'h80, 8'h34, 8'h12, 8'h00, 8'h00,
		  8'hAA, 8'h55, 8'h00, 8'h00, 8'hEF, 8'hBE, 8'hAD, 8'hDE}};
	// Flags, address, compare, replace
	logic [127:0] cheat_exp [n_cheat] = '{
		{32'h03020100, 32'h07060504, 32'h0B0A0908, 32'h0F0E0D0C},
		{32'h80000001, 32'h00001234, 32'h000055AA, 32'hDEADBEEF}};

	cart_top i_dut (.*);

	always #10 clk_sys = ~clk_sys;

	always @(negedge clk_sys) begin
		if (code_valid) valid_pulses++;
	end

	// Byte pattern of the cartridge image by address
	function automatic logic [dl_data_w-1:0] fill_byte(input logic [dl_addr_w-1:0] a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ {a[24], 7'h35};
	endfunction

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// ==========================================================================
	// ROM memory model answering each toggle after 0 to 7 cycles
	// ==========================================================================
	initial begin : rom_responder
		logic [31:0] lfsr;
		logic [2:0]  delay;
		rom_wr_ack = 1'b0;
		lfsr = lfsr_seed;
		delay = '0;
		forever begin
			@(negedge clk_sys);
			if (rst_n && (rom_wr_req != rom_wr_ack)) begin
				check_wr_addr("rom_wr_addr", rom_wr_addr_w'(rom_writes - cart_base), rom_wr_addr);
				check_data("ROM write data", fill_byte(dl_addr_w'(rom_writes - cart_base)),
					dl_data);
				rom_writes++;
				for (int i = 0; i < 3; i++) begin
					lfsr = next_lfsr(lfsr);
					delay = {delay[1:0], lfsr[0]};
				end
				repeat (delay) begin
					@(negedge clk_sys);
					check_bit("dl_wait while write pending", 1'b1, dl_wait);
				end
				rom_wr_ack = rom_wr_req;
			end
		end
	end

	function automatic string count_line();
		return $sformatf("Checks: %0d, errors: %0d, ROM writes: %0d, code pulses: %0d",
			n_checks, n_errors, rom_writes, valid_pulses);
	endfunction

	task automatic abort_run(input string what);
		n_errors++;
		$display("%s", what);
		$display("%s", count_line());
		$display("Finished with errors");
		$fatal(1, "Simulation stopped early");
	endtask

	task automatic finish_run();
		$display("%s", count_line());
		if (n_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	endtask

	// Host holds off until the write has been answered
	task automatic wait_ready();
		int n;
		n = 0;
		while (dl_wait) begin
			@(negedge clk_sys);
			n++;
			if (n > ready_timeout) abort_run("Timeout: dl_wait stayed high after a ROM write");
		end
	endtask

	task automatic send_byte(input logic [dl_addr_w-1:0] addr, input logic [7:0] data,
			input logic cart);
		logic req_before;
		req_before = rom_wr_req;
		dl_addr = addr;
		dl_data = data;
		dl_wr = 1'b1;
		@(negedge clk_sys);
		dl_wr = 1'b0;
		if (cart) begin
			check_bit("dl_wait after write", 1'b1, dl_wait);
			check_bit("rom_wr_req toggle", ~req_before, rom_wr_req);
		end else begin
			check_bit("dl_wait on cheat write", 1'b0, dl_wait);
		end
		wait_ready();
	endtask

	// ==========================================================================
	// Test sequences
	// ==========================================================================
	task automatic check_enables();
		int seen [4];
		int last [4];
		logic [3:0] ce_vec;
		seen = '{0, 0, 0, 0};
		last = '{0, 0, 0, 0};
		for (int k = 0; k < 2 * ce_period; k++) begin
			@(negedge clk_sys);
			ce_vec = {ce_sp, ce_pix, ce_vdp, ce_cpu};
			for (int j = 0; j < 4; j++) begin
				if (ce_vec[j]) begin
					if (seen[j] == 0) check_count({ce_name[j], " first pulse"}, ce_first[j], k);
					else check_count({ce_name[j], " spacing"}, ce_gap[j], k - last[j]);
					last[j] = k;
					seen[j]++;
				end
			end
		end
		for (int j = 0; j < 4; j++) begin
			check_count({ce_name[j], " pulses"}, ce_total[j], seen[j]);
		end
	endtask

	task automatic load_cart(input int c);
		$display("Cartridge case %0d: index %h, %0d bytes", c, cart_index[c], cart_len[c]);
		cart_base = rom_writes;
		dl_index = cart_index[c];
		dl_active = 1'b1;
		@(negedge clk_sys);  // Start of download clears the write address
		for (int a = 0; a < cart_len[c]; a++) begin
			send_byte(dl_addr_w'(a), fill_byte(dl_addr_w'(a)), 1'b1);
		end
		dl_active = 1'b0;
		@(negedge clk_sys);
		@(negedge clk_sys);
		check_count("ROM writes per download", cart_len[c], rom_writes - cart_base);
		check_bit("game_gear", cart_gg[c], game_gear);
		for (int j = 0; j < 4; j++) begin
			rom_rd_addr = rd_tab[c][j];
			@(negedge clk_sys);
			check_addr($sformatf("rom_mem_addr case %0d read %0d", c, j), mem_tab[c][j],
				rom_mem_addr);
		end
	endtask

	task automatic load_cheat(input int c);
		int writes_before;
		int pulses_before;
		logic req_before;
		cheat_code_t exp_code;
		writes_before = rom_writes;
		pulses_before = valid_pulses;
		req_before = rom_wr_req;
		exp_code = cheat_exp[c];
		dl_index = code_index;
		dl_active = 1'b1;
		@(negedge clk_sys);
		for (int b = 0; b < code_bytes; b++) begin
			send_byte(dl_addr_w'(b), cheat_tab[c][b], 1'b0);
		end
		check_bit("code_valid after offset 15", 1'b1, code_valid);
		dl_active = 1'b0;
		@(negedge clk_sys);
		@(negedge clk_sys);
		check_count("code_valid pulses", pulses_before + 1, valid_pulses);
		check_code($sformatf("cheat code %0d", c), exp_code, code);
		check_count("ROM writes during cheat", writes_before, rom_writes);
		check_bit("rom_wr_req during cheat", req_before, rom_wr_req);
	endtask

	initial begin
		rst_n = 1'b0;
		dl_active = 1'b0;
		dl_index = '0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		rom_rd_addr = '0;
		repeat (4) @(negedge clk_sys);
		check_bit("dl_wait in reset", 1'b0, dl_wait);
		check_bit("code_valid in reset", 1'b0, code_valid);
		check_bit("rom_wr_req in reset", 1'b0, rom_wr_req);
		check_bit("game_gear in reset", 1'b0, game_gear);
		check_bit("ce_cpu in reset", 1'b0, ce_cpu);
		check_bit("ce_vdp in reset", 1'b0, ce_vdp);
		check_bit("ce_pix in reset", 1'b0, ce_pix);
		check_bit("ce_sp in reset", 1'b0, ce_sp);
		rst_n = 1'b1;
		check_enables();
		for (int c = 0; c < n_cart; c++) load_cart(c);
		for (int c = 0; c < n_cheat; c++) load_cheat(c);
		finish_run();
	end

endmodule

// ==== build.f ====
+incdir+test
source/sys_pkg.sv
source/cheat_pkg.sv
source/download_if.sv
source/clock_enables.sv
source/cart_writer.sv
source/cart_mapper.sv
source/cheat_loader.sv
source/cart_top.sv
test/tb_cart_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cart_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0
PASS_MSG  ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
